//--- source/shell_config.svh
// Board shell configuration
// address map, identifiers and divider ratios

`ifndef SHELL_CONFIG_SVH
`define SHELL_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// bus widths
////////////////////////////////////////////////////////////////////////////

// apb address and data
`define SHELL_ADDR_W 32
`define SHELL_DATA_W 32

////////////////////////////////////////////////////////////////////////////
// address map and constants
////////////////////////////////////////////////////////////////////////////

// register slave window, everything else goes to the error slave
`define SHELL_REGS_BASE 32'h0000_0000
`define SHELL_REGS_SIZE 32'h0000_0100

// read-only identifier and error read data
`define SHELL_ID_VALUE  32'hC5E5_0001
`define SHELL_ERR_VALUE 32'hBADC_AB1E

// soc_clk cycles per rtc half period, 50 MHz in, 1 MHz out
`define SHELL_RTC_HALF 25

// fan level width, 16 pwm steps
`define SHELL_FAN_W 4

`endif

//--- source/shell_pkg.sv
// Board shell types

`include "shell_config.svh"

package shell_pkg;

  // apb request from the external master
  typedef struct packed {
    logic [`SHELL_ADDR_W-1:0] paddr;
    logic                     pwrite;
    logic [`SHELL_DATA_W-1:0] pwdata;
    logic                     psel;
    logic                     penable;
  } apb_req_t;

  // apb response back to the master
  typedef struct packed {
    logic [`SHELL_DATA_W-1:0] prdata;
    logic                     pready;
    logic                     pslverr;
  } apb_rsp_t;

  // fan control, override bit above the level
  typedef struct packed {
    logic                    ovr_en;
    logic [`SHELL_FAN_W-1:0] level;
  } fan_cfg_t;

  // register offsets inside the register window
  typedef enum logic [7:0] {
    REG_ID      = 8'h00,
    REG_FAN     = 8'h04,
    REG_RTC     = 8'h08,
    REG_SCRATCH = 8'h0C
  } reg_off_e;

endpackage

//--- source/shell_apb_decoder.sv
// APB address decoder

`timescale 1ns/10ps

`include "shell_config.svh"

module shell_apb_decoder
  import shell_pkg::*;
(
  input  apb_req_t apb_req_i,
  output apb_rsp_t apb_rsp_o,
  output apb_req_t regs_req_o,
  input  apb_rsp_t regs_rsp_i,
  output apb_req_t err_req_o,
  input  apb_rsp_t err_rsp_i
);

  logic                     regs_hit;
  logic [`SHELL_ADDR_W-1:0] regs_off;

  // offset relative to the register window
  // subtract first so a zero base needs no lower bound compare
  assign regs_off = apb_req_i.paddr - `SHELL_ADDR_W'(`SHELL_REGS_BASE);
  assign regs_hit = (regs_off < `SHELL_ADDR_W'(`SHELL_REGS_SIZE));

  ////////////////////////////////////////////////////////////////////////////
  // request fan-out
  ////////////////////////////////////////////////////////////////////////////

  // payload goes to both branches
  // only one branch ever sees psel
  always_comb begin
    regs_req_o      = apb_req_i;
    err_req_o       = apb_req_i;
    regs_req_o.psel = apb_req_i.psel & regs_hit;
    err_req_o.psel  = apb_req_i.psel & ~regs_hit;
  end

  ////////////////////////////////////////////////////////////////////////////
  // response mux
  ////////////////////////////////////////////////////////////////////////////

  // same decode picks the answer, unselected slave is idle anyway
  assign apb_rsp_o = regs_hit ? regs_rsp_i : err_rsp_i;

endmodule

//--- source/shell_err_slv.sv
// APB default error slave

`timescale 1ns/10ps

`include "shell_config.svh"

module shell_err_slv
  import shell_pkg::*;
(
  input  logic     soc_clk,
  input  logic     rst_n,
  input  apb_req_t apb_req_i,
  output apb_rsp_t apb_rsp_o
);

  logic access;

  // access phase of a transfer aimed at us
  assign access = apb_req_i.psel & apb_req_i.penable;

  // always ready, always refuses
  assign apb_rsp_o.pready  = access;
  assign apb_rsp_o.pslverr = access;
  // reads see the marker value
  assign apb_rsp_o.prdata  = (access & ~apb_req_i.pwrite) ? `SHELL_ERR_VALUE : '0;

endmodule

//--- source/shell_regs.sv
// APB register file
// ID, fan control, rtc time and scratch

`timescale 1ns/10ps

`include "shell_config.svh"

module shell_regs
  import shell_pkg::*;
(
  input  logic     soc_clk,
  input  logic     rst_n,
  input  apb_req_t apb_req_i,
  output apb_rsp_t apb_rsp_o,
  input  logic     rtc_tick_i,
  output fan_cfg_t fan_cfg_o
);

  reg_off_e                 reg_off;
  logic                     access;
  logic                     wr_en;
  logic                     mapped;
  logic [`SHELL_DATA_W-1:0] rdata;

  fan_cfg_t                 fan_q;
  logic [`SHELL_DATA_W-1:0] rtc_q;
  logic [`SHELL_DATA_W-1:0] scratch_q;

  // window is 256 bytes, low byte is the offset
  assign reg_off = reg_off_e'(apb_req_i.paddr[7:0]);
  assign access  = apb_req_i.psel & apb_req_i.penable;
  assign wr_en   = access & apb_req_i.pwrite;

  ////////////////////////////////////////////////////////////////////////////
  // read decode
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    mapped = 1'b1;
    rdata  = '0;
    case (reg_off)
      REG_ID:      rdata = `SHELL_ID_VALUE;
      REG_FAN:     rdata = `SHELL_DATA_W'(fan_q);
      REG_RTC:     rdata = rtc_q;
      REG_SCRATCH: rdata = scratch_q;
      // holes in the window read zero with an error
      default:     mapped = 1'b0;
    endcase
  end

  // no wait states
  assign apb_rsp_o.pready  = access;
  assign apb_rsp_o.pslverr = access & ~mapped;
  // read data only in the access cycle of a read
  assign apb_rsp_o.prdata  = (access & ~apb_req_i.pwrite) ? rdata : '0;

  ////////////////////////////////////////////////////////////////////////////
  // writable registers
  ////////////////////////////////////////////////////////////////////////////

  // fan control, override off and level zero out of reset
  always_ff @(posedge soc_clk, negedge rst_n) begin
    if (!rst_n) begin
      fan_q <= '0;
    end else if (wr_en && reg_off == REG_FAN) begin
      fan_q <= fan_cfg_t'(apb_req_i.pwdata[`SHELL_FAN_W:0]);
    end
  end

  // scratch holds software data only
  always_ff @(posedge soc_clk) begin
    if (wr_en && reg_off == REG_SCRATCH) begin
      scratch_q <= apb_req_i.pwdata;
    end
  end

  // rtc time in rtc periods
  // writes to ID and RTC fall through silently
  always_ff @(posedge soc_clk, negedge rst_n) begin
    if (!rst_n) begin
      rtc_q <= '0;
    end else if (rtc_tick_i) begin
      rtc_q <= rtc_q + 1'b1;
    end
  end

  assign fan_cfg_o = fan_q;

endmodule

//--- source/shell_rtc_div.sv
// RTC clock divider

`timescale 1ns/10ps

`include "shell_config.svh"

module shell_rtc_div (
  input  logic soc_clk,
  input  logic rst_n,
  output logic rtc_clk_o,
  output logic rtc_tick_o
);

  localparam int unsigned CntW = $clog2(`SHELL_RTC_HALF);

  logic [CntW-1:0] cnt_q;
  logic            wrap;
  logic            rtc_clk_q;
  logic            tick_q;

  // last cycle of a half period
  assign wrap = (cnt_q == CntW'(`SHELL_RTC_HALF - 1));

  // half period counter and rtc clock
  // tick is registered so it lines up with the rising edge
  always_ff @(posedge soc_clk, negedge rst_n) begin
    if (!rst_n) begin
      cnt_q     <= '0;
      rtc_clk_q <= 1'b0;
      tick_q    <= 1'b0;
    end else begin
      tick_q <= wrap & ~rtc_clk_q;
      if (wrap) begin
        cnt_q     <= '0;
        rtc_clk_q <= ~rtc_clk_q;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  assign rtc_clk_o  = rtc_clk_q;
  assign rtc_tick_o = tick_q;

endmodule

//--- source/shell_fan_pwm.sv
// Fan level select and PWM

`timescale 1ns/10ps

`include "shell_config.svh"

module shell_fan_pwm
  import shell_pkg::*;
(
  input  logic                    soc_clk,
  input  logic                    rst_n,
  input  logic [`SHELL_FAN_W-1:0] fan_sw_i,
  input  fan_cfg_t                fan_cfg_i,
  output logic                    fan_pwm_o
);

  logic [`SHELL_FAN_W-1:0] fan_level;
  logic [`SHELL_FAN_W-1:0] phase_q;
  logic                    pwm_q;

  // register level wins over the board switches
  assign fan_level = fan_cfg_i.ovr_en ? fan_cfg_i.level : fan_sw_i;

  ////////////////////////////////////////////////////////////////////////////
  // pwm generator
  ////////////////////////////////////////////////////////////////////////////

  // phase wraps every 16 cycles
  // output high for level cycles per period, level 0 stays low
  always_ff @(posedge soc_clk, negedge rst_n) begin
    if (!rst_n) begin
      phase_q <= '0;
      pwm_q   <= 1'b0;
    end else begin
      phase_q <= phase_q + 1'b1;
      pwm_q   <= (phase_q < fan_level);
    end
  end

  assign fan_pwm_o = pwm_q;

endmodule

//--- source/shell_top.sv
// Board shell top level

`timescale 1ns/10ps

`include "shell_config.svh"

module shell_top
  import shell_pkg::*;
(
  input  logic                    soc_clk,
  input  logic                    rst_n,
  input  apb_req_t                apb_req_i,
  output apb_rsp_t                apb_rsp_o,
  input  logic [`SHELL_FAN_W-1:0] fan_sw_i,
  output logic                    fan_pwm_o,
  output logic                    rtc_clk_o
);

  apb_req_t regs_req;
  apb_rsp_t regs_rsp;
  apb_req_t err_req;
  apb_rsp_t err_rsp;
  logic     rtc_tick;
  fan_cfg_t fan_cfg;

  ////////////////////////////////////////////////////////////////////////////
  // register bus
  ////////////////////////////////////////////////////////////////////////////

  shell_apb_decoder i_apb_decoder (
    .apb_req_i  ( apb_req_i ),
    .apb_rsp_o  ( apb_rsp_o ),
    .regs_req_o ( regs_req  ),
    .regs_rsp_i ( regs_rsp  ),
    .err_req_o  ( err_req   ),
    .err_rsp_i  ( err_rsp   )
  );

  // regs slave
  shell_regs i_regs (
    .soc_clk    ( soc_clk   ),
    .rst_n      ( rst_n     ),
    .apb_req_i  ( regs_req  ),
    .apb_rsp_o  ( regs_rsp  ),
    .rtc_tick_i ( rtc_tick  ),
    .fan_cfg_o  ( fan_cfg   )
  );

  // catches everything outside the map
  shell_err_slv i_err_slv (
    .soc_clk   ( soc_clk ),
    .rst_n     ( rst_n   ),
    .apb_req_i ( err_req ),
    .apb_rsp_o ( err_rsp )
  );

  ////////////////////////////////////////////////////////////////////////////
  // rtc and fan
  ////////////////////////////////////////////////////////////////////////////

  shell_rtc_div i_rtc_div (
    .soc_clk    ( soc_clk   ),
    .rst_n      ( rst_n     ),
    .rtc_clk_o  ( rtc_clk_o ),
    .rtc_tick_o ( rtc_tick  )
  );

  shell_fan_pwm i_fan_pwm (
    .soc_clk   ( soc_clk   ),
    .rst_n     ( rst_n     ),
    .fan_sw_i  ( fan_sw_i  ),
    .fan_cfg_i ( fan_cfg   ),
    .fan_pwm_o ( fan_pwm_o )
  );

endmodule

//--- dv/shell_props.sv
// APB and PWM assertions

`timescale 1ns/10ps

`include "shell_config.svh"

module shell_props
  import shell_pkg::*;
(
  input logic                    soc_clk,
  input logic                    rst_n,
  input apb_req_t                apb_req_i,
  input apb_rsp_t                apb_rsp_i,
  input apb_req_t                regs_req_i,
  input apb_req_t                err_req_i,
  input logic [`SHELL_FAN_W-1:0] fan_sw_i,
  input fan_cfg_t                fan_cfg_i,
  input logic                    fan_pwm_i
);

  logic                    access;
  logic [`SHELL_FAN_W-1:0] eff_level;

  assign access    = apb_req_i.psel & apb_req_i.penable;
  // level as the fan block sees it
  assign eff_level = fan_cfg_i.ovr_en ? fan_cfg_i.level : fan_sw_i;

  // no wait states on either slave
  a_ready: assert property (@(posedge soc_clk) disable iff (!rst_n)
    access |-> apb_rsp_i.pready)
    else $error("pready low in access cycle");

  a_slverr: assert property (@(posedge soc_clk) disable iff (!rst_n)
    apb_rsp_i.pslverr |-> access)
    else $error("pslverr outside access cycle");

  // decoder selects one branch at most
  a_one_sel: assert property (@(posedge soc_clk) disable iff (!rst_n)
    !(regs_req_i.psel && err_req_i.psel))
    else $error("both slaves selected");

  // pwm output is registered, so one cycle later
  a_pwm_off: assert property (@(posedge soc_clk) disable iff (!rst_n)
    (eff_level == '0) |=> !fan_pwm_i)
    else $error("fan pwm high at level zero");

endmodule

bind shell_top shell_props i_shell_props (
  .soc_clk    ( soc_clk   ),
  .rst_n      ( rst_n     ),
  .apb_req_i  ( apb_req_i ),
  .apb_rsp_i  ( apb_rsp_o ),
  .regs_req_i ( regs_req  ),
  .err_req_i  ( err_req   ),
  .fan_sw_i   ( fan_sw_i  ),
  .fan_cfg_i  ( fan_cfg   ),
  .fan_pwm_i  ( fan_pwm_o )
);

//--- dv/shell_tb.sv
// Board shell testbench
// directed tests over APB, fan PWM and rtc

`timescale 1ns/10ps

`include "shell_config.svh"

module shell_tb
  import shell_pkg::*;
();

  localparam int unsigned ReadyTimeout  = 16;
  localparam int unsigned ToggleTimeout = 100;

  logic                    soc_clk;
  logic                    rst_n;
  apb_req_t                apb_req;
  apb_rsp_t                apb_rsp;
  logic [`SHELL_FAN_W-1:0] fan_sw;
  logic                    fan_pwm;
  logic                    rtc_clk;
  int                      seed;

  shell_top i_shell_top (
    .soc_clk   ( soc_clk ),
    .rst_n     ( rst_n   ),
    .apb_req_i ( apb_req ),
    .apb_rsp_o ( apb_rsp ),
    .fan_sw_i  ( fan_sw  ),
    .fan_pwm_o ( fan_pwm ),
    .rtc_clk_o ( rtc_clk )
  );

  // 100 ns soc_clk
  initial begin
    soc_clk = 1'b0;
    forever #50 soc_clk = ~soc_clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // error handling and compares
  ////////////////////////////////////////////////////////////////////////////

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic report_mismatch(input string what);
    stop_run($sformatf("MISMATCH at time %0t: %s", $time, what));
  endtask

  // read data only matters on reads
  task automatic compare_rsp(input apb_rsp_t got, input apb_rsp_t exp, input logic is_read,
                             input string what);
    if ((is_read && got.prdata !== exp.prdata) || got.pslverr !== exp.pslverr) begin
      report_mismatch($sformatf("%s: prdata %h pslverr %b, expected prdata %h pslverr %b",
                                what, got.prdata, got.pslverr, exp.prdata, exp.pslverr));
    end
  endtask

  task automatic compare_level(input int unsigned got, input int unsigned exp,
                               input string what);
    if (got != exp) begin
      report_mismatch($sformatf("%s: %0d pwm high cycles, expected %0d", what, got, exp));
    end
  endtask

  task automatic compare_period(input int unsigned got, input int unsigned exp);
    if (got != exp) begin
      report_mismatch($sformatf("rtc half period %0d cycles, expected %0d", got, exp));
    end
  endtask

  // 1000 cycles at 50 cycles per tick, one tick of slack for phase
  task automatic compare_rtc_delta(input logic [`SHELL_DATA_W-1:0] first,
                                   input logic [`SHELL_DATA_W-1:0] second);
    logic [`SHELL_DATA_W-1:0] delta;
    delta = second - first;
    if (delta < 32'd19 || delta > 32'd21) begin
      report_mismatch($sformatf("rtc advanced by %0d over 1000 cycles, expected 20", delta));
    end
  endtask

  function automatic apb_rsp_t expect_rsp(input logic [`SHELL_DATA_W-1:0] data,
                                          input logic err);
    apb_rsp_t rsp;
    rsp.prdata  = data;
    rsp.pready  = 1'b1;
    rsp.pslverr = err;
    return rsp;
  endfunction

  function automatic logic [`SHELL_ADDR_W-1:0] reg_addr(input reg_off_e off);
    return `SHELL_REGS_BASE + {24'h0, off};
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // apb driver, called on a falling edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic apb_transfer(input logic [`SHELL_ADDR_W-1:0] addr, input logic write,
                              input logic [`SHELL_DATA_W-1:0] wdata, output apb_rsp_t rsp);
    int unsigned waited;
    // setup cycle
    apb_req.paddr   = addr;
    apb_req.pwrite  = write;
    apb_req.pwdata  = wdata;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    @(negedge soc_clk);
    // access cycle, held until pready
    apb_req.penable = 1'b1;
    waited = 0;
    do begin
      @(posedge soc_clk);
      waited++;
    end while (!apb_rsp.pready && waited < ReadyTimeout);
    if (!apb_rsp.pready) begin
      stop_run($sformatf("timeout waiting for pready at address %h", addr));
    end
    rsp = apb_rsp;
    @(negedge soc_clk);
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
  endtask

  task automatic apb_write(input logic [`SHELL_ADDR_W-1:0] addr,
                           input logic [`SHELL_DATA_W-1:0] data, output apb_rsp_t rsp);
    apb_transfer(addr, 1'b1, data, rsp);
  endtask

  task automatic apb_read(input logic [`SHELL_ADDR_W-1:0] addr, output apb_rsp_t rsp);
    apb_transfer(addr, 1'b0, '0, rsp);
  endtask

  // settle the registered output, then 64 cycles = four pwm periods
  task automatic check_pwm(input int unsigned level, input string what);
    int unsigned high;
    repeat (2) @(negedge soc_clk);
    high = 0;
    repeat (64) begin
      @(posedge soc_clk);
      if (fan_pwm) begin
        high++;
      end
    end
    compare_level(high, 4 * level, what);
    @(negedge soc_clk);
  endtask

  // cycles until rtc_clk_o changes
  task automatic wait_rtc_toggle(output int unsigned cycles);
    logic start;
    start  = rtc_clk;
    cycles = 0;
    do begin
      @(posedge soc_clk);
      cycles++;
    end while (rtc_clk == start && cycles < ToggleTimeout);
    if (rtc_clk == start) begin
      stop_run("timeout: rtc_clk_o did not toggle");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_id_read();
    apb_rsp_t rsp;
    apb_read(reg_addr(REG_ID), rsp);
    compare_rsp(rsp, expect_rsp(`SHELL_ID_VALUE, 1'b0), 1'b1, "ID read");
    // ID is read only, write is dropped quietly
    apb_write(reg_addr(REG_ID), 32'h0123_4567, rsp);
    compare_rsp(rsp, expect_rsp('0, 1'b0), 1'b0, "ID write");
    apb_read(reg_addr(REG_ID), rsp);
    compare_rsp(rsp, expect_rsp(`SHELL_ID_VALUE, 1'b0), 1'b1, "ID read after write");
  endtask

  task automatic test_scratch();
    logic [`SHELL_DATA_W-1:0] data;
    apb_rsp_t                 rsp;
    for (int i = 0; i < 8; i++) begin
      data = $random(seed);
      apb_write(reg_addr(REG_SCRATCH), data, rsp);
      compare_rsp(rsp, expect_rsp('0, 1'b0), 1'b0, "scratch write");
      apb_read(reg_addr(REG_SCRATCH), rsp);
      compare_rsp(rsp, expect_rsp(data, 1'b0), 1'b1, "scratch read back");
    end
  endtask

  task automatic test_error_paths();
    apb_rsp_t rsp;
    // first address past the window, then far away
    apb_read(`SHELL_REGS_BASE + `SHELL_REGS_SIZE, rsp);
    compare_rsp(rsp, expect_rsp(`SHELL_ERR_VALUE, 1'b1), 1'b1, "read past window");
    apb_read(32'h8000_0000, rsp);
    compare_rsp(rsp, expect_rsp(`SHELL_ERR_VALUE, 1'b1), 1'b1, "read far outside");
    apb_write(32'hFFFF_FFFC, 32'h5A5A_5A5A, rsp);
    compare_rsp(rsp, expect_rsp('0, 1'b1), 1'b0, "write outside");
    // holes inside the window
    apb_read(`SHELL_REGS_BASE + 32'h10, rsp);
    compare_rsp(rsp, expect_rsp('0, 1'b1), 1'b1, "read hole 0x10");
    apb_read(`SHELL_REGS_BASE + 32'hFC, rsp);
    compare_rsp(rsp, expect_rsp('0, 1'b1), 1'b1, "read hole 0xFC");
    apb_write(`SHELL_REGS_BASE + 32'h20, 32'h1234_5678, rsp);
    compare_rsp(rsp, expect_rsp('0, 1'b1), 1'b0, "write hole 0x20");
  endtask

  task automatic test_fan_switch();
    for (int unsigned lvl = 0; lvl < 16; lvl += 5) begin
      fan_sw = `SHELL_FAN_W'(lvl);
      check_pwm(lvl, $sformatf("switch level %0d", lvl));
    end
  endtask

  task automatic test_fan_override();
    fan_cfg_t cfg;
    apb_rsp_t rsp;
    fan_sw = 4'd15;
    cfg.ovr_en = 1'b1;
    cfg.level  = 4'd3;
    apb_write(reg_addr(REG_FAN), `SHELL_DATA_W'(cfg), rsp);
    apb_read(reg_addr(REG_FAN), rsp);
    compare_rsp(rsp, expect_rsp(`SHELL_DATA_W'(cfg), 1'b0), 1'b1, "fan register read");
    check_pwm(3, "override level 3");
    // zero override silences the fan against full switches
    cfg.level = 4'd0;
    apb_write(reg_addr(REG_FAN), `SHELL_DATA_W'(cfg), rsp);
    check_pwm(0, "override level 0");
    apb_write(reg_addr(REG_FAN), '0, rsp);
    check_pwm(15, "override cleared");
  endtask

  task automatic test_rtc();
    logic [`SHELL_DATA_W-1:0] rtc_first;
    int unsigned              cycles;
    apb_rsp_t                 rsp;
    apb_read(reg_addr(REG_RTC), rsp);
    rtc_first = rsp.prdata;
    // second access cycle lands 1000 cycles after the first
    repeat (998) @(negedge soc_clk);
    apb_read(reg_addr(REG_RTC), rsp);
    compare_rtc_delta(rtc_first, rsp.prdata);
    // align to an edge, then time two half periods
    wait_rtc_toggle(cycles);
    repeat (2) begin
      wait_rtc_toggle(cycles);
      compare_period(cycles, `SHELL_RTC_HALF);
    end
    @(negedge soc_clk);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    seed    = 60760;
    rst_n   = 1'b0;
    apb_req = '0;
    fan_sw  = '0;
    repeat (10) @(posedge soc_clk);
    @(negedge soc_clk);
    rst_n = 1'b1;
    @(negedge soc_clk);
    if (rtc_clk !== 1'b0 || fan_pwm !== 1'b0 || apb_rsp.pslverr !== 1'b0 ||
        apb_rsp.pready !== 1'b0) begin
      report_mismatch("outputs not idle after reset");
    end
    test_id_read();
    test_scratch();
    test_error_paths();
    test_fan_switch();
    test_fan_override();
    test_rtc();
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

//--- sim.f
+incdir+source
source/shell_pkg.sv
source/shell_apb_decoder.sv
source/shell_err_slv.sv
source/shell_regs.sv
source/shell_rtc_div.sv
source/shell_fan_pwm.sv
source/shell_top.sv
dv/shell_props.sv
dv/shell_tb.sv

//--- run.sh
#!/bin/sh
# build and run the board shell testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module shell_tb -f sim.f; then
  echo "Verilator build failed"
  exit 1
fi

if ! sim_out=$(./obj_dir/Vshell_tb); then
  echo "$sim_out"
  echo "simulation exited with an error"
  exit 1
fi
echo "$sim_out"

if echo "$sim_out" | grep -q "ALL TESTS PASSED"; then
  exit 0
fi

echo "pass message not found in simulation output"
exit 1
